// File: verilog/mt_fetch_pkg.sv
// mt_fetch_pkg
// Shared types and constants for the multithreaded fetch front end.
// Holds the word and hart-id types, the quantum, the instruction cache
// geometry and the per-hart reset PC rule.

package mt_fetch_pkg;

    // ============================================================
    // data and thread types
    // ============================================================
    typedef logic [31:0] word_t;                       // one data or address word.

    localparam int NUM_HARTS = 4;                      // hardware threads in the core.
    typedef logic [$clog2(NUM_HARTS)-1:0] hart_t;      // hart index, 2 bits for 4 harts.

    localparam int QUANTUM  = 10;                      // accepted fetches before return to hart 0.
    localparam int QCOUNT_W = $clog2(QUANTUM + 1);     // counter holds 0 up to QUANTUM.

    // ============================================================
    // instruction cache geometry
    // ============================================================
    localparam int ICACHE_LINES = 16;                  // one word per line.
    localparam int OFFSET_W     = 2;                   // byte offset inside a word.
    localparam int INDEX_W      = $clog2(ICACHE_LINES);
    localparam int TAG_W        = 32 - INDEX_W - OFFSET_W;

    typedef logic [INDEX_W-1:0] index_t;               // line select.
    typedef logic [TAG_W-1:0]   tag_t;                 // address bits above the index.

    // ============================================================
    // reset program counters
    // ============================================================
    localparam word_t RESET_PC      = 32'h0000_0000;   // start address of hart 0.
    localparam word_t RESET_PC_STEP = 32'h0000_0100;   // spacing between hart start addresses.

    // hart n starts at RESET_PC plus n times the step.
    function automatic word_t hart_reset_pc(hart_t h);
        return RESET_PC + RESET_PC_STEP * word_t'(h);
    endfunction

endpackage

// File: verilog/hart_selector.sv
// hart_selector
// Picks the hart that fetches. A cache miss moves fetch to the next hart,
// and after QUANTUM accepted fetches the selector falls back to hart 0.

`timescale 1ns/1ps

module hart_selector (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                pc_en,
    input  logic                if_ex_flush,
    input  logic                instr_valid,
    input  logic                cache_miss,
    output mt_fetch_pkg::hart_t hart_id
);

    logic [mt_fetch_pkg::QCOUNT_W-1:0] count;          // accepted fetches in this quantum.
    logic [mt_fetch_pkg::QCOUNT_W-1:0] next_count;
    mt_fetch_pkg::hart_t               next_hart_id;
    logic                              accept;         // a fetch leaves the front end.
    logic                              quantum_done;   // count has reached QUANTUM.

    assign accept       = instr_valid && pc_en && !if_ex_flush;
    assign quantum_done = (count == mt_fetch_pkg::QCOUNT_W'(mt_fetch_pkg::QUANTUM));

    // ============================================================
    // state registers
    // ============================================================
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count   <= '0;                             // quantum starts empty.
            hart_id <= '0;                             // fetch begins on hart 0.
        end else begin
            count   <= next_count;
            hart_id <= next_hart_id;
        end
    end

    // the count only moves on an accepted fetch and wraps after QUANTUM.
    always_comb begin
        next_count = count;
        if (accept) begin
            if (quantum_done) begin
                next_count = '0;
            end else begin
                next_count = count + 1'b1;
            end
        end
    end

    // Next hart. A miss outranks the quantum return.
    always_comb begin
        next_hart_id = hart_id;                        // stay by default.
        if (cache_miss) begin
            if (hart_id == mt_fetch_pkg::hart_t'(mt_fetch_pkg::NUM_HARTS - 1)) begin
                next_hart_id = '0;                     // wrap past the last hart.
            end else begin
                next_hart_id = hart_id + 1'b1;
            end
        end else if (quantum_done && hart_id != '0) begin
            next_hart_id = '0;                         // quantum used up, back to hart 0.
        end
    end

endmodule

// File: verilog/pc_file.sv
// pc_file
// One program counter per hart. The selected hart's PC steps by 4 on each
// accepted fetch, and a redirect can load any hart's PC from outside.

`timescale 1ns/1ps

module pc_file (
    input  logic                CLK,
    input  logic                nRST,
    input  mt_fetch_pkg::hart_t hart_id,
    input  logic                advance,
    input  logic                redirect_en,
    input  mt_fetch_pkg::hart_t redirect_hart,
    input  mt_fetch_pkg::word_t redirect_pc,
    output mt_fetch_pkg::word_t pc
);

    mt_fetch_pkg::word_t pcs [mt_fetch_pkg::NUM_HARTS]; // program counter of each hart.

    // ============================================================
    // per-hart PC update
    // ============================================================
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int h = 0; h < mt_fetch_pkg::NUM_HARTS; h++) begin
                pcs[h] <= mt_fetch_pkg::hart_reset_pc(mt_fetch_pkg::hart_t'(h));
            end
        end else begin
            for (int h = 0; h < mt_fetch_pkg::NUM_HARTS; h++) begin
                if (redirect_en && redirect_hart == mt_fetch_pkg::hart_t'(h)) begin
                    pcs[h] <= redirect_pc;             // a redirect beats the increment.
                end else if (advance && hart_id == mt_fetch_pkg::hart_t'(h)) begin
                    pcs[h] <= pcs[h] + 32'd4;          // next sequential instruction.
                end
            end
        end
    end

    // the selected hart's PC goes straight to the cache lookup.
    assign pc = pcs[hart_id];

endmodule

// File: verilog/icache.sv
// icache
// Direct-mapped instruction cache, one word per line. Hits answer in the
// same cycle. A miss while idle starts a single refill over the shared bus,
// and the line is written on the edge where the bus read completes.

`timescale 1ns/1ps

module icache (
    input  logic                CLK,
    input  logic                nRST,
    input  mt_fetch_pkg::word_t pc,
    output logic                instr_valid,
    output mt_fetch_pkg::word_t instr,
    output logic                cache_miss,
    output logic                ren,
    output mt_fetch_pkg::word_t addr,
    input  mt_fetch_pkg::word_t rdata,
    input  logic                busy
);

    typedef enum logic {
        IDLE,                                          // no refill running.
        REFILL                                         // waiting on the bus read.
    } state_t;

    state_t state;
    state_t next_state;

    logic                valid_q [mt_fetch_pkg::ICACHE_LINES]; // line holds a word.
    mt_fetch_pkg::tag_t  tag_q   [mt_fetch_pkg::ICACHE_LINES];
    mt_fetch_pkg::word_t data_q  [mt_fetch_pkg::ICACHE_LINES];

    mt_fetch_pkg::index_t pc_index;
    mt_fetch_pkg::tag_t   pc_tag;
    mt_fetch_pkg::word_t  miss_addr;                   // address under refill.
    mt_fetch_pkg::index_t fill_index;
    logic                 hit;
    logic                 fill_done;                   // bus read finishes this cycle.

    // ============================================================
    // lookup
    // ============================================================
    assign pc_index = pc[mt_fetch_pkg::OFFSET_W +: mt_fetch_pkg::INDEX_W];
    assign pc_tag   = pc[31 -: mt_fetch_pkg::TAG_W];
    assign hit      = valid_q[pc_index] && (tag_q[pc_index] == pc_tag);

    assign instr_valid = hit;
    assign instr       = data_q[pc_index];
    assign cache_miss  = !hit && (state == IDLE);      // a busy engine makes the hart wait.

    // ============================================================
    // refill engine
    // ============================================================
    assign ren        = (state == REFILL);
    assign addr       = {miss_addr[31:mt_fetch_pkg::OFFSET_W], 2'b00};
    assign fill_index = miss_addr[mt_fetch_pkg::OFFSET_W +: mt_fetch_pkg::INDEX_W];
    assign fill_done  = (state == REFILL) && !busy;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (cache_miss) next_state = REFILL;
            REFILL:  if (!busy) next_state = IDLE;     // the word arrives with busy low.
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            for (int i = 0; i < mt_fetch_pkg::ICACHE_LINES; i++) begin
                valid_q[i] <= 1'b0;                    // cache comes up empty.
            end
        end else begin
            state <= next_state;
            if (fill_done) begin
                valid_q[fill_index] <= 1'b1;
            end
        end
    end

    // line storage and the address of the running refill.
    always_ff @(posedge CLK) begin
        if (cache_miss) begin
            miss_addr <= pc;                           // latch the missing fetch address.
        end
        if (fill_done) begin
            tag_q[fill_index]  <= miss_addr[31 -: mt_fetch_pkg::TAG_W];
            data_q[fill_index] <= rdata;
        end
    end

endmodule

// File: verilog/bus_arbiter.sv
// bus_arbiter
// Shares one memory bus between the cache refill and the core's data port.
// The owner is chosen at a clock edge with the cache first, kept through
// busy, and released when its access completes.

`timescale 1ns/1ps

module bus_arbiter (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                ic_ren,
    input  mt_fetch_pkg::word_t ic_addr,
    output mt_fetch_pkg::word_t ic_rdata,
    output logic                ic_busy,
    input  logic                d_ren,
    input  logic                d_wen,
    input  mt_fetch_pkg::word_t d_addr,
    input  mt_fetch_pkg::word_t d_wdata,
    output mt_fetch_pkg::word_t d_rdata,
    output logic                d_busy,
    output logic                mem_ren,
    output logic                mem_wen,
    output mt_fetch_pkg::word_t mem_addr,
    output mt_fetch_pkg::word_t mem_wdata,
    input  mt_fetch_pkg::word_t mem_rdata,
    input  logic                mem_busy
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_CACHE,
        OWN_DATA
    } owner_t;

    owner_t owner;
    owner_t next_owner;
    logic   d_req;                                     // data port wants the bus.

    assign d_req = d_ren || d_wen;

    // ============================================================
    // ownership
    // ============================================================
    always_comb begin
        next_owner = owner;
        case (owner)
            OWN_NONE: begin
                if (ic_ren) next_owner = OWN_CACHE;    // refill wins a tie.
                else if (d_req) next_owner = OWN_DATA;
            end
            OWN_CACHE: if (!ic_ren || !mem_busy) next_owner = OWN_NONE;
            OWN_DATA:  if (!d_req || !mem_busy) next_owner = OWN_NONE;
            default:   next_owner = OWN_NONE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner <= OWN_NONE;
        end else begin
            owner <= next_owner;
        end
    end

    // ============================================================
    // bus mux
    // ============================================================
    always_comb begin
        mem_ren   = 1'b0;                              // idle bus drives nothing.
        mem_wen   = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        if (owner == OWN_CACHE) begin
            mem_ren  = ic_ren;                         // refill only reads.
            mem_addr = ic_addr;
        end else if (owner == OWN_DATA) begin
            mem_ren   = d_ren;
            mem_wen   = d_wen;
            mem_addr  = d_addr;
            mem_wdata = d_wdata;
        end
    end

    assign ic_rdata = mem_rdata;                       // both sides see the read word.
    assign d_rdata  = mem_rdata;

    // a requester that is not the owner sees busy while it waits or the peer holds the bus.
    assign ic_busy = (owner == OWN_CACHE) ? mem_busy : (ic_ren || owner == OWN_DATA);
    assign d_busy  = (owner == OWN_DATA) ? mem_busy : (d_req || owner == OWN_CACHE);

endmodule

// File: verilog/mt_fetch_top.sv
// mt_fetch_top
// Multithreaded fetch front end. Ties the hart selector, the PC file, the
// instruction cache and the bus arbiter together, and brings out the fetch
// port, the core's data port and the shared memory bus.

`timescale 1ns/1ps

module mt_fetch_top (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                pc_en,
    input  logic                if_ex_flush,
    input  logic                redirect_en,
    input  mt_fetch_pkg::hart_t redirect_hart,
    input  mt_fetch_pkg::word_t redirect_pc,
    output logic                instr_valid,
    output mt_fetch_pkg::word_t instr,
    output mt_fetch_pkg::hart_t instr_hart,
    output mt_fetch_pkg::word_t instr_pc,
    input  logic                d_ren,
    input  logic                d_wen,
    input  mt_fetch_pkg::word_t d_addr,
    input  mt_fetch_pkg::word_t d_wdata,
    output mt_fetch_pkg::word_t d_rdata,
    output logic                d_busy,
    output logic                mem_ren,
    output logic                mem_wen,
    output mt_fetch_pkg::word_t mem_addr,
    output mt_fetch_pkg::word_t mem_wdata,
    input  mt_fetch_pkg::word_t mem_rdata,
    input  logic                mem_busy
);

    mt_fetch_pkg::hart_t hart_id;                      // hart that fetches this cycle.
    mt_fetch_pkg::word_t pc;
    logic                cache_miss;
    logic                advance;                      // fetch accepted by the pipeline.
    logic                ic_ren;
    mt_fetch_pkg::word_t ic_addr;
    mt_fetch_pkg::word_t ic_rdata;
    logic                ic_busy;

    assign advance    = instr_valid && pc_en && !if_ex_flush;
    assign instr_hart = hart_id;
    assign instr_pc   = pc;

    // ============================================================
    // fetch path
    // ============================================================
    hart_selector u_hart_selector (
        .CLK         (CLK),
        .nRST        (nRST),
        .pc_en       (pc_en),
        .if_ex_flush (if_ex_flush),
        .instr_valid (instr_valid),
        .cache_miss  (cache_miss),
        .hart_id     (hart_id)
    );

    pc_file u_pc_file (
        .CLK           (CLK),
        .nRST          (nRST),
        .hart_id       (hart_id),
        .advance       (advance),
        .redirect_en   (redirect_en),
        .redirect_hart (redirect_hart),
        .redirect_pc   (redirect_pc),
        .pc            (pc)
    );

    icache u_icache (
        .CLK         (CLK),
        .nRST        (nRST),
        .pc          (pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .cache_miss  (cache_miss),
        .ren         (ic_ren),
        .addr        (ic_addr),
        .rdata       (ic_rdata),
        .busy        (ic_busy)
    );

    // ============================================================
    // shared memory bus
    // ============================================================
    bus_arbiter u_bus_arbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .ic_ren    (ic_ren),
        .ic_addr   (ic_addr),
        .ic_rdata  (ic_rdata),
        .ic_busy   (ic_busy),
        .d_ren     (d_ren),
        .d_wen     (d_wen),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_rdata   (d_rdata),
        .d_busy    (d_busy),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy)
    );

endmodule

// File: tests/tb_clock.sv
// tb_clock
// Clock and reset source for the testbench. CLK runs with a 10 ns period,
// and nRST is held low for the first 2 rising edges.

`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;                                    // first rising edge at 5 ns.
        forever #5 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;                                   // reset from time zero.
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;                                   // release away from the active edge.
    end

endmodule

// File: tests/tb_mem_model.sv
// tb_mem_model
// Memory on the shared bus for the testbench. An unwritten word reads as
// its address XOR A5A5_0000, written words are kept in a small table,
// and every access stays busy for 1 to 3 cycles.

`timescale 1ns/1ps

module tb_mem_model (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                mem_ren,
    input  logic                mem_wen,
    input  mt_fetch_pkg::word_t mem_addr,
    input  mt_fetch_pkg::word_t mem_wdata,
    output mt_fetch_pkg::word_t mem_rdata,
    output logic                mem_busy
);

    localparam int SLOTS = 16;                         // written words the model can hold.

    integer              seed = 32'hb5dc;
    logic [31:0]         draw;
    logic                in_access;                    // the access is past its first cycle.
    int                  wait_left;                    // busy cycles still to go.
    int                  slot;
    logic                slot_used [SLOTS];
    mt_fetch_pkg::word_t slot_addr [SLOTS];
    mt_fetch_pkg::word_t slot_data [SLOTS];

    // used slots form a prefix, so a match always comes before a free slot.
    function automatic int find_slot(mt_fetch_pkg::word_t addr);
        int found;
        found = -1;
        for (int i = 0; i < SLOTS; i++) begin
            if (found < 0 && (!slot_used[i] || slot_addr[i] == addr)) found = i;
        end
        return found;
    endfunction

    function automatic mt_fetch_pkg::word_t read_word(mt_fetch_pkg::word_t addr);
        int s;
        s = find_slot(addr);
        if (s >= 0) begin
            if (slot_used[s]) return slot_data[s];     // a written word wins.
        end
        return addr ^ 32'hA5A5_0000;                   // fill pattern over the whole address.
    endfunction

    // busy is high on the first cycle of every access and while wait_left runs.
    assign mem_busy = (mem_ren || mem_wen) && (!in_access || wait_left != 0);

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            in_access <= 1'b0;
            wait_left <= 0;
            mem_rdata <= '0;
            for (int i = 0; i < SLOTS; i++) slot_used[i] <= 1'b0;
        end else if (mem_ren || mem_wen) begin
            if (!in_access) begin
                draw      = $random(seed);
                in_access <= 1'b1;
                wait_left <= int'(draw[7:0]) % 3;      // 0 to 2 more busy cycles.
                mem_rdata <= read_word(mem_addr);      // address is held for the whole access.
            end else if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                in_access <= 1'b0;                     // busy is low, the access ends here.
                if (mem_wen) begin
                    slot = find_slot(mem_addr);
                    if (slot >= 0) begin
                        slot_used[slot] <= 1'b1;
                        slot_addr[slot] <= mem_addr;
                        slot_data[slot] <= mem_wdata;
                    end
                end
            end
        end else begin
            in_access <= 1'b0;
        end
    end

endmodule

// File: tests/tb_mt_fetch.sv
// tb_mt_fetch
// Testbench for the multithreaded fetch front end. Drives fetch levels,
// redirects and data port traffic on the falling edge, and checks every
// cycle against a reference of hart selection, PCs and the refill engine.

`timescale 1ns/1ps

module tb_mt_fetch;

    localparam mt_fetch_pkg::word_t PATTERN   = 32'hA5A5_0000; // memory fill pattern.
    localparam mt_fetch_pkg::word_t LOOP_BASE = 32'h0000_1000; // each hart loops on its own lines.
    localparam mt_fetch_pkg::word_t DATA_BASE = 32'h0000_8000; // data words, never fetched.
    localparam int                  TIMEOUT   = 200;           // cycles allowed for any wait.

    logic                CLK;
    logic                nRST;
    logic                pc_en;
    logic                if_ex_flush;
    logic                redirect_en;
    mt_fetch_pkg::hart_t redirect_hart;
    mt_fetch_pkg::word_t redirect_pc;
    logic                instr_valid;
    mt_fetch_pkg::word_t instr;
    mt_fetch_pkg::hart_t instr_hart;
    mt_fetch_pkg::word_t instr_pc;
    logic                d_ren;
    logic                d_wen;
    mt_fetch_pkg::word_t d_addr;
    mt_fetch_pkg::word_t d_wdata;
    mt_fetch_pkg::word_t d_rdata;
    logic                d_busy;
    logic                mem_ren;
    logic                mem_wen;
    mt_fetch_pkg::word_t mem_addr;
    mt_fetch_pkg::word_t mem_wdata;
    mt_fetch_pkg::word_t mem_rdata;
    logic                mem_busy;

    // ============================================================
    // reference state
    // ============================================================
    integer              seed = 32'hb5dc;
    logic [31:0]         draw;
    int                  exp_hart;                     // hart expected in this cycle.
    int                  exp_count;                    // accepted fetches in the quantum.
    mt_fetch_pkg::word_t exp_pc [mt_fetch_pkg::NUM_HARTS];
    logic                refill_busy;                  // the cache has a refill running.
    mt_fetch_pkg::word_t refill_addr;
    logic                accept;
    logic                miss;
    int                  accepts = 0;
    int                  miss_switches = 0;
    int                  quantum_returns = 0;
    int                  data_checks = 0;
    mt_fetch_pkg::word_t wr_addr_q [$];                // data writes done so far.
    mt_fetch_pkg::word_t wr_data_q [$];

    tb_clock u_clock (.CLK(CLK), .nRST(nRST));

    mt_fetch_top u_dut (
        .CLK(CLK), .nRST(nRST), .pc_en(pc_en), .if_ex_flush(if_ex_flush),
        .redirect_en(redirect_en), .redirect_hart(redirect_hart), .redirect_pc(redirect_pc),
        .instr_valid(instr_valid), .instr(instr), .instr_hart(instr_hart), .instr_pc(instr_pc),
        .d_ren(d_ren), .d_wen(d_wen), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_rdata(d_rdata), .d_busy(d_busy), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

    tb_mem_model u_mem (
        .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input mt_fetch_pkg::word_t got,
                               input mt_fetch_pkg::word_t want);
        assert (got == want) else
            report_failure($sformatf("[ERROR] %s: expected %h, got %h", name, want, got));
    endtask

    // memory contents as the testbench knows them. Later writes win.
    function automatic mt_fetch_pkg::word_t expected_word(mt_fetch_pkg::word_t addr);
        mt_fetch_pkg::word_t value;
        value = addr ^ PATTERN;
        for (int i = 0; i < wr_addr_q.size(); i++) begin
            if (wr_addr_q[i] == addr) value = wr_data_q[i];
        end
        return value;
    endfunction

    // ============================================================
    // cycle checker
    // ============================================================
    // reset values are sampled on the falling edge, after the DUT has been reset.
    always @(negedge CLK) begin
        if (!nRST) begin
            check_value("instr_hart", 32'(instr_hart), 32'd0);
            check_value("instr_valid", 32'(instr_valid), 32'd0);
            check_value("mem_ren", 32'(mem_ren), 32'd0);
            check_value("mem_wen", 32'(mem_wen), 32'd0);
            check_value("d_busy", 32'(d_busy), 32'd0);   // no data request during reset.
        end
    end

    always @(posedge CLK) begin
        if (!nRST) begin
            exp_hart    = 0;
            exp_count   = 0;
            refill_busy = 1'b0;
            for (int h = 0; h < mt_fetch_pkg::NUM_HARTS; h++) begin
                exp_pc[h] = mt_fetch_pkg::RESET_PC + 32'h100 * 32'(h);
            end
        end else begin
            accept = instr_valid && pc_en && !if_ex_flush;
            miss   = !instr_valid && !refill_busy;     // a waiting hart raises no miss.
            check_value("instr_hart", 32'(instr_hart), 32'(exp_hart));
            if (accept) begin
                check_value("instr_pc", instr_pc, exp_pc[instr_hart]);
                check_value("instr", instr, expected_word(instr_pc));
                exp_pc[instr_hart] = exp_pc[instr_hart] + 32'd4;
                accepts++;
            end
            if (redirect_en) exp_pc[redirect_hart] = redirect_pc; // beats the increment.
            // the refill ends when the cache owns the bus and busy drops.
            if (refill_busy && mem_ren && !mem_busy && d_busy) begin
                check_value("mem_addr", mem_addr, refill_addr);
                refill_busy = 1'b0;
            end
            if (miss) begin
                refill_busy = 1'b1;
                refill_addr = {instr_pc[31:2], 2'b00};
                exp_hart    = (exp_hart + 1) % mt_fetch_pkg::NUM_HARTS;
                miss_switches++;
            end else if (exp_count == mt_fetch_pkg::QUANTUM && exp_hart != 0) begin
                exp_hart = 0;                          // quantum used up.
                quantum_returns++;
            end
            if (accept) exp_count = (exp_count == mt_fetch_pkg::QUANTUM) ? 0 : exp_count + 1;
            // d_busy low with a request means the data port owns the bus.
            if ((d_ren || d_wen) && !d_busy) begin
                check_value("mem_ren", 32'(mem_ren), 32'(d_ren));
                check_value("mem_wen", 32'(mem_wen), 32'(d_wen));
                check_value("mem_addr", mem_addr, d_addr);
                if (d_wen) check_value("mem_wdata", mem_wdata, d_wdata);
            end
        end
    end

    // ============================================================
    // stimulus
    // ============================================================
    task automatic await_reset_release();
        int waited;
        waited = 0;
        while (!nRST) begin
            waited++;
            if (waited > TIMEOUT) report_failure("reset was never released");
            @(negedge CLK);
        end
    endtask

    task automatic wait_for_refill();
        int waited;
        waited = 0;
        @(negedge CLK);
        while (!mem_ren) begin
            waited++;
            if (waited > TIMEOUT) report_failure("no cache refill reached the memory bus");
            @(negedge CLK);
        end
    endtask

    task automatic hold_until_granted(input string what, output mt_fetch_pkg::word_t seen);
        int waited;
        waited = 0;
        @(posedge CLK);
        while (d_busy) begin
            waited++;
            if (waited > TIMEOUT) report_failure($sformatf("%s never got the bus", what));
            @(posedge CLK);
        end
        seen = d_rdata;                                // word of the completing access.
    endtask

    // each hart is kept on four lines of its own, so the lines stay cached.
    task automatic steer_into_loop();
        mt_fetch_pkg::word_t base;
        base          = LOOP_BASE + 32'h10 * 32'(instr_hart);
        redirect_en   = 1'b0;
        redirect_hart = instr_hart;
        redirect_pc   = base;
        if (instr_pc < base || instr_pc > base + 32'hC) begin
            redirect_en = 1'b1;
        end else if (instr_pc == base + 32'hC && instr_valid && pc_en && !if_ex_flush) begin
            redirect_en = 1'b1;                        // jump back on the last accepted word.
        end
    endtask

    task automatic fetch_stimulus();
        for (int c = 0; c < 550; c++) begin
            @(negedge CLK);
            draw        = $random(seed);
            pc_en       = (draw[2:0] != 3'd0);         // mostly enabled.
            if_ex_flush = (draw[7:4] == 4'd0);         // a flush now and then.
            if (c >= 150) steer_into_loop();           // first part runs straight through.
        end
        @(negedge CLK);
        pc_en       = 1'b0;
        redirect_en = 1'b0;
    endtask

    task automatic data_traffic();
        mt_fetch_pkg::word_t addr;
        mt_fetch_pkg::word_t seen;
        for (int i = 0; i < 3; i++) begin
            addr = DATA_BASE + 32'd4 * 32'(i);
            wait_for_refill();                         // start while the cache holds the bus.
            d_wen   = 1'b1;
            d_addr  = addr;
            d_wdata = addr ^ 32'h0F0F_F0F0;
            hold_until_granted("data write", seen);
            wr_addr_q.push_back(addr);
            wr_data_q.push_back(addr ^ 32'h0F0F_F0F0);
            @(negedge CLK);
            d_wen = 1'b0;
            wait_for_refill();
            d_ren = 1'b1;
            hold_until_granted("data read", seen);
            check_value("d_rdata", seen, expected_word(addr));
            data_checks++;
            @(negedge CLK);
            d_ren = 1'b0;
        end
    endtask

    initial begin
        pc_en         = 1'b0;
        if_ex_flush   = 1'b0;
        redirect_en   = 1'b0;
        redirect_hart = '0;
        redirect_pc   = '0;
        d_ren         = 1'b0;
        d_wen         = 1'b0;
        d_addr        = '0;
        d_wdata       = '0;
        await_reset_release();
        fork
            fetch_stimulus();
            data_traffic();
        join
        @(negedge CLK);
        if (accepts > 0 && miss_switches > 0 && quantum_returns > 0 && data_checks == 3) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("the run ended without reaching every check");
        end
    end

endmodule

// File: mt_fetch.f
verilog/mt_fetch_pkg.sv
verilog/hart_selector.sv
verilog/pc_file.sv
verilog/icache.sv
verilog/bus_arbiter.sv
verilog/mt_fetch_top.sv
tests/tb_clock.sv
tests/tb_mem_model.sv
tests/tb_mt_fetch.sv
